// ==== core_pkg.sv ====
package core_pkg;

    localparam int reg_size = 8;
    localparam int reg_ptr_size = 4;
    localparam int reg_count = 2 ** reg_ptr_size;
    localparam int insn_size = 16;
    localparam int insn_count = 32;
    localparam int insn_ptr_size = 5;
    localparam int addr_size = 16;
    localparam int opcode_size = 4;
    localparam int shift_size = $clog2(reg_size);

    typedef logic [reg_size-1:0] data_t;
    typedef logic [reg_ptr_size-1:0] reg_ptr_t;
    typedef logic [insn_size-1:0] insn_t;
    typedef logic [insn_ptr_size-1:0] insn_ptr_t;
    typedef logic [addr_size-1:0] addr_t;

    // low bit of each instruction field
    localparam int opcode_lsb = 12;
    localparam int field_a_lsb = 8;
    localparam int field_b_lsb = 4;
    localparam int field_c_lsb = 0;
    localparam int const_lsb = 0;
    localparam int target_lsb = 4;

    typedef enum logic [opcode_size-1:0] {
        op_nop       = 4'd0,
        op_add       = 4'd1,
        op_sub       = 4'd2,
        op_mul       = 4'd3,
        op_div       = 4'd4,
        op_cmpge     = 4'd5,
        op_rshift    = 4'd6,
        op_lshift    = 4'd7,
        op_and       = 4'd8,
        op_or        = 4'd9,
        op_xor       = 4'd10,
        op_ld        = 4'd11,
        op_st        = 4'd12,
        op_set_const = 4'd13,
        op_bnz       = 4'd14,
        op_halt      = 4'd15
    } opcode_t;

    typedef logic [1:0] mem_op_t;

    localparam mem_op_t mem_none = 2'b00;
    localparam mem_op_t mem_load = 2'b01;
    localparam mem_op_t mem_store = 2'b10;

    typedef struct packed {
        opcode_t   opcode;
        reg_ptr_t  dest;
        logic      write;
        data_t     val_a;
        data_t     val_b;
        data_t     val_c;
        data_t     constant;
        insn_ptr_t target;
        logic      valid;
    } decoded_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_ptr_t dest;
        logic     write;
        data_t    result;
        addr_t    addr;
        data_t    store_data;
        logic     valid;
    } executed_t;

endpackage

// ==== insn_memory.sv ====
`timescale 1ns/1ps

module insn_memory (
    input  logic                                          clk,
    input  logic                                          load,
    input  core_pkg::insn_t [core_pkg::insn_count-1:0]    insn_data,
    input  core_pkg::insn_ptr_t                           read_ptr,
    output core_pkg::insn_t                               insn
);

    core_pkg::insn_t slots [core_pkg::insn_count];

    // whole program captured in one cycle
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            for (int i = 0; i < core_pkg::insn_count; i++)
            begin
                slots[i] <= insn_data[i]; // slot i sits at bits 16*i and up
            end
        end
    end

    assign insn = slots[read_ptr]; // async read

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic                 init_r0,
    input  core_pkg::data_t      init_r0_data,
    input  core_pkg::reg_ptr_t   read_a,
    input  core_pkg::reg_ptr_t   read_b,
    input  core_pkg::reg_ptr_t   read_c,
    output core_pkg::data_t      data_a,
    output core_pkg::data_t      data_b,
    output core_pkg::data_t      data_c,
    input  logic                 wb_en,
    input  core_pkg::reg_ptr_t   wb_reg,
    input  core_pkg::data_t      wb_data
);

    core_pkg::data_t regs [core_pkg::reg_count];

    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            for (int i = 0; i < core_pkg::reg_count; i++)
            begin
                regs[i] <= '0;
            end
            if (init_r0)
                regs[0] <= init_r0_data; // start value overrides the clear
        end
        else if (wb_en)
        begin
            regs[wb_reg] <= wb_data;
        end
    end

    // write-through so decode sees the writeback in the same cycle
    assign data_a = (wb_en && wb_reg == read_a) ? wb_data : regs[read_a];
    assign data_b = (wb_en && wb_reg == read_b) ? wb_data : regs[read_b];
    assign data_c = (wb_en && wb_reg == read_c) ? wb_data : regs[read_c];

endmodule

// ==== core_decode.sv ====
`timescale 1ns/1ps

module core_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_run,
    input  logic                  hold,
    input  core_pkg::insn_t       insn,
    output core_pkg::insn_ptr_t   read_ptr,
    output core_pkg::reg_ptr_t    read_a,
    output core_pkg::reg_ptr_t    read_b,
    output core_pkg::reg_ptr_t    read_c,
    input  core_pkg::data_t       data_a,
    input  core_pkg::data_t       data_b,
    input  core_pkg::data_t       data_c,
    input  logic                  redirect,
    input  core_pkg::insn_ptr_t   redirect_target,
    input  core_pkg::decoded_t    ex_stage,
    input  core_pkg::executed_t   res_stage,
    output core_pkg::decoded_t    decoded
);

    core_pkg::insn_t fetch_insn;
    core_pkg::insn_t next_insn;
    core_pkg::opcode_t opcode;
    logic fetch_valid;
    logic running; // low once a halt has issued
    logic past_last; // pointer has stepped past the last slot
    logic uses_a;
    logic uses_b;
    logic uses_c;
    logic hazard;

    function automatic logic pending_write(
        input core_pkg::reg_ptr_t  src,
        input core_pkg::decoded_t  ex,
        input core_pkg::executed_t res
    );
        return (ex.valid && ex.write && ex.dest == src) ||
               (res.valid && res.write && res.dest == src);
    endfunction

    // the slot after the last one reads as a halt
    assign next_insn = past_last ?
        {core_pkg::op_halt, {(core_pkg::insn_size - core_pkg::opcode_size){1'b0}}} : insn;

    assign opcode = core_pkg::opcode_t'(fetch_insn[core_pkg::opcode_lsb +: core_pkg::opcode_size]);
    assign read_a = fetch_insn[core_pkg::field_a_lsb +: core_pkg::reg_ptr_size];
    assign read_b = fetch_insn[core_pkg::field_b_lsb +: core_pkg::reg_ptr_size];
    assign read_c = fetch_insn[core_pkg::field_c_lsb +: core_pkg::reg_ptr_size];

    always_comb
    begin
        uses_a = 1'b0;
        uses_b = 1'b0;
        uses_c = 1'b0;
        decoded.opcode = opcode;
        decoded.dest = read_c;
        decoded.write = 1'b0;
        decoded.val_a = data_a;
        decoded.val_b = data_b;
        decoded.val_c = data_c;
        decoded.constant = fetch_insn[core_pkg::const_lsb +: core_pkg::reg_size];
        decoded.target = fetch_insn[core_pkg::target_lsb +: core_pkg::insn_ptr_size];
        case (opcode)
            core_pkg::op_add, core_pkg::op_sub, core_pkg::op_mul, core_pkg::op_div,
            core_pkg::op_cmpge, core_pkg::op_rshift, core_pkg::op_lshift,
            core_pkg::op_and, core_pkg::op_or, core_pkg::op_xor, core_pkg::op_ld:
            begin
                uses_a = 1'b1;
                uses_b = 1'b1;
                decoded.write = 1'b1;
            end
            core_pkg::op_st:
            begin
                uses_a = 1'b1;
                uses_b = 1'b1;
                uses_c = 1'b1; // store data
            end
            core_pkg::op_bnz:
                uses_c = 1'b1;
            core_pkg::op_set_const:
            begin
                decoded.dest = read_a;
                decoded.write = 1'b1;
            end
            default:
                decoded.write = 1'b0;
        endcase
        hazard = fetch_valid && (
            (uses_a && pending_write(read_a, ex_stage, res_stage)) ||
            (uses_b && pending_write(read_b, ex_stage, res_stage)) ||
            (uses_c && pending_write(read_c, ex_stage, res_stage)));
        decoded.valid = fetch_valid && !hazard && !redirect; // bubble on stall or flush
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_ptr <= '0;
            fetch_valid <= 1'b0;
            running <= 1'b0;
            past_last <= 1'b0;
        end
        else if (start_run)
        begin
            read_ptr <= '0;
            fetch_valid <= 1'b0;
            running <= 1'b1;
            past_last <= 1'b0;
        end
        else if (!hold)
        begin
            if (redirect)
            begin
                read_ptr <= redirect_target;
                fetch_valid <= 1'b0; // second bubble
                past_last <= 1'b0;
            end
            else if (decoded.valid && opcode == core_pkg::op_halt)
            begin
                running <= 1'b0;
                fetch_valid <= 1'b0;
            end
            else if (!hazard)
            begin
                fetch_valid <= running;
                read_ptr <= read_ptr + 1'b1;
                past_last <= past_last ||
                    (read_ptr == core_pkg::insn_ptr_t'(core_pkg::insn_count - 1));
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!hold && !hazard)
            fetch_insn <= next_insn;
    end

endmodule

// ==== core_execute.sv ====
`timescale 1ns/1ps

module core_execute (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_run,
    input  logic                  hold,
    input  core_pkg::decoded_t    decoded,
    output core_pkg::decoded_t    ex_stage,
    output logic                  redirect,
    output core_pkg::insn_ptr_t   redirect_target,
    output core_pkg::executed_t   executed
);

    core_pkg::data_t op_a;
    core_pkg::data_t op_b;
    core_pkg::data_t alu_result;
    logic [core_pkg::shift_size-1:0] shift;

    always_ff @(posedge clk)
    begin
        if (reset || start_run)
            ex_stage.valid <= 1'b0;
        else if (!hold)
            ex_stage <= decoded;
    end

    assign op_a = ex_stage.val_a;
    assign op_b = ex_stage.val_b;
    assign shift = op_b[core_pkg::shift_size-1:0];

    always_comb
    begin
        case (ex_stage.opcode)
            core_pkg::op_add:       alu_result = op_a + op_b;
            core_pkg::op_sub:       alu_result = op_a - op_b;
            core_pkg::op_mul:       alu_result = op_a * op_b; // low byte only
            core_pkg::op_div:       alu_result = (op_b == '0) ? '1 : op_a / op_b;
            core_pkg::op_cmpge:     alu_result = core_pkg::data_t'(op_a >= op_b);
            core_pkg::op_rshift:    alu_result = op_a >> shift;
            core_pkg::op_lshift:    alu_result = op_a << shift;
            core_pkg::op_and:       alu_result = op_a & op_b;
            core_pkg::op_or:        alu_result = op_a | op_b;
            core_pkg::op_xor:       alu_result = op_a ^ op_b;
            core_pkg::op_set_const: alu_result = ex_stage.constant;
            default:                alu_result = '0;
        endcase
    end

    // branch resolves here and flushes fetch and decode
    assign redirect = ex_stage.valid && ex_stage.opcode == core_pkg::op_bnz &&
                      ex_stage.val_c != '0;
    assign redirect_target = ex_stage.target;

    always_ff @(posedge clk)
    begin
        if (reset || start_run)
        begin
            executed.valid <= 1'b0;
        end
        else if (!hold)
        begin
            executed.opcode <= ex_stage.opcode;
            executed.dest <= ex_stage.dest;
            executed.write <= ex_stage.write;
            executed.result <= alu_result;
            executed.addr <= {op_a, op_b}; // high byte from field a
            executed.store_data <= ex_stage.val_c;
            executed.valid <= ex_stage.valid;
        end
    end

endmodule

// ==== core_result.sv ====
`timescale 1ns/1ps

module core_result (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  core_pkg::executed_t   executed,
    input  core_pkg::data_t       rd_data,
    input  logic                  ready_sig,
    output core_pkg::addr_t       addr,
    output core_pkg::data_t       wr_data,
    output core_pkg::mem_op_t     enable,
    output logic                  hold,
    output logic                  wb_en,
    output core_pkg::reg_ptr_t    wb_reg,
    output core_pkg::data_t       wb_data,
    output logic                  ready,
    output logic                  start_run
);

    logic bus_wait;

    always_comb
    begin
        enable = core_pkg::mem_none;
        if (executed.valid && executed.opcode == core_pkg::op_ld)
            enable = core_pkg::mem_load;
        else if (executed.valid && executed.opcode == core_pkg::op_st)
            enable = core_pkg::mem_store;
    end

    // stage is frozen during the wait so the bus stays steady
    assign addr = executed.addr;
    assign wr_data = executed.store_data;

    assign bus_wait = (enable != core_pkg::mem_none) && !ready_sig;
    assign hold = bus_wait || ready;

    assign wb_en = executed.valid && executed.write && !hold;
    assign wb_reg = executed.dest;
    assign wb_data = (executed.opcode == core_pkg::op_ld) ? rd_data : executed.result;

    assign start_run = start && ready; // start only counts while idle

    always_ff @(posedge clk)
    begin
        if (reset)
            ready <= 1'b1;
        else if (start_run)
            ready <= 1'b0;
        else if (executed.valid && executed.opcode == core_pkg::op_halt && !hold)
            ready <= 1'b1;
    end

endmodule

// ==== core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          start,
    input  core_pkg::insn_t [core_pkg::insn_count-1:0]    insn_data,
    input  logic                                          init_r0_flag,
    input  core_pkg::data_t                               init_r0_data,
    output core_pkg::addr_t                               addr,
    output core_pkg::data_t                               wr_data,
    output core_pkg::mem_op_t                             enable,
    input  core_pkg::data_t                               rd_data,
    input  logic                                          ready_sig,
    output logic                                          ready
);

    logic start_run;
    logic hold;
    logic redirect;
    logic wb_en;
    core_pkg::insn_ptr_t read_ptr;
    core_pkg::insn_ptr_t redirect_target;
    core_pkg::insn_t insn;
    core_pkg::reg_ptr_t read_a;
    core_pkg::reg_ptr_t read_b;
    core_pkg::reg_ptr_t read_c;
    core_pkg::reg_ptr_t wb_reg;
    core_pkg::data_t data_a;
    core_pkg::data_t data_b;
    core_pkg::data_t data_c;
    core_pkg::data_t wb_data;
    core_pkg::decoded_t decoded;
    core_pkg::decoded_t ex_stage;
    core_pkg::executed_t executed;

    insn_memory i_insn_memory (
        .clk       (clk),
        .load      (start_run),
        .insn_data (insn_data),
        .read_ptr  (read_ptr),
        .insn      (insn)
    );

    register_file i_register_file (
        .clk          (clk),
        .reset        (reset),
        .clear        (start_run),
        .init_r0      (start_run && init_r0_flag),
        .init_r0_data (init_r0_data),
        .read_a       (read_a),
        .read_b       (read_b),
        .read_c       (read_c),
        .data_a       (data_a),
        .data_b       (data_b),
        .data_c       (data_c),
        .wb_en        (wb_en),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data)
    );

    core_decode i_core_decode (
        .clk             (clk),
        .reset           (reset),
        .start_run       (start_run),
        .hold            (hold),
        .insn            (insn),
        .read_ptr        (read_ptr),
        .read_a          (read_a),
        .read_b          (read_b),
        .read_c          (read_c),
        .data_a          (data_a),
        .data_b          (data_b),
        .data_c          (data_c),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .ex_stage        (ex_stage),
        .res_stage       (executed),
        .decoded         (decoded)
    );

    core_execute i_core_execute (
        .clk             (clk),
        .reset           (reset),
        .start_run       (start_run),
        .hold            (hold),
        .decoded         (decoded),
        .ex_stage        (ex_stage),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .executed        (executed)
    );

    core_result i_core_result (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .executed  (executed),
        .rd_data   (rd_data),
        .ready_sig (ready_sig),
        .addr      (addr),
        .wr_data   (wr_data),
        .enable    (enable),
        .hold      (hold),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .ready     (ready),
        .start_run (start_run)
    );

endmodule

// ==== core_assertions.sv ====
`timescale 1ns/1ps

module core_assertions (
    input logic                clk,
    input logic                reset,
    input core_pkg::addr_t     addr,
    input core_pkg::data_t     wr_data,
    input core_pkg::mem_op_t   enable,
    input logic                ready_sig,
    input logic                ready
);

    int fail_count = 0;

    enable_legal: assert property (@(posedge clk) disable iff (reset)
        enable != 2'b11)
    else
    begin
        $error("enable took the unused code 11");
        fail_count++;
    end

    // request held until the memory answers
    bus_steady: assert property (@(posedge clk) disable iff (reset)
        (enable != core_pkg::mem_none && !ready_sig) |=>
        ($stable(enable) && $stable(addr) && $stable(wr_data)))
    else
    begin
        $error("bus request changed before ready_sig");
        fail_count++;
    end

    idle_bus: assert property (@(posedge clk) disable iff (reset)
        ready |-> enable == core_pkg::mem_none)
    else
    begin
        $error("bus access while the core is idle");
        fail_count++;
    end

endmodule

bind core_top core_assertions i_core_assertions (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .wr_data   (wr_data),
    .enable    (enable),
    .ready_sig (ready_sig),
    .ready     (ready)
);

// ==== core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    typedef struct packed {
        core_pkg::mem_op_t op;
        core_pkg::addr_t   addr;
        core_pkg::data_t   data;
    } access_t;

    localparam int run_limit = 4000; // cycles per program run
    localparam core_pkg::insn_t halt_word = {core_pkg::op_halt, 12'h000};
    localparam core_pkg::insn_t nop_word = {core_pkg::op_nop, 12'h000};

    logic clk;
    logic reset;
    logic start;
    core_pkg::insn_t [core_pkg::insn_count-1:0] insn_data;
    logic init_r0_flag;
    core_pkg::data_t init_r0_data;
    core_pkg::addr_t addr;
    core_pkg::data_t wr_data;
    core_pkg::mem_op_t enable;
    core_pkg::data_t rd_data = '0;
    logic ready_sig = 1'b0;
    logic ready;

    core_pkg::insn_t [core_pkg::insn_count-1:0] prog;
    int prog_len;
    core_pkg::data_t dmem [65536];
    core_pkg::data_t ref_mem [65536];
    access_t bus_log [$];
    access_t exp_log [$];
    logic [31:0] lat_state = 32'd34;
    logic [31:0] data_state = 32'd34;
    int wait_left = -1;

    core_top i_core_top (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .insn_data    (insn_data),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .addr         (addr),
        .wr_data      (wr_data),
        .enable       (enable),
        .rd_data      (rd_data),
        .ready_sig    (ready_sig),
        .ready        (ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic core_pkg::data_t random_byte();
        data_state = xorshift(data_state);
        return data_state[7:0];
    endfunction

    // data memory with 0 to 3 cycles of latency per access
    always @(negedge clk)
    begin
        access_t rec;
        ready_sig = 1'b0;
        if (reset || enable == core_pkg::mem_none)
            wait_left = -1;
        else
        begin
            if (wait_left < 0)
            begin
                lat_state = xorshift(lat_state);
                wait_left = lat_state % 4;
            end
            if (wait_left == 0)
            begin
                rec.op = enable;
                rec.addr = addr;
                if (enable == core_pkg::mem_store)
                begin
                    dmem[addr] = wr_data;
                    rec.data = wr_data;
                end
                else
                begin
                    rd_data = dmem[addr];
                    rec.data = rd_data;
                end
                bus_log.push_back(rec);
                ready_sig = 1'b1; // access completes on the next rising edge
                wait_left = -1;
            end
            else
                wait_left--;
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    always @(posedge clk)
    begin
        if (i_core_top.i_core_assertions.fail_count != 0)
            report_failure("a bus protocol assertion failed");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
    endtask

    function automatic core_pkg::insn_t alu_insn(input core_pkg::opcode_t op,
        input core_pkg::reg_ptr_t a, input core_pkg::reg_ptr_t b, input core_pkg::reg_ptr_t c);
        return {op, a, b, c};
    endfunction

    function automatic core_pkg::insn_t const_insn(input core_pkg::reg_ptr_t a,
                                                   input core_pkg::data_t k);
        return {core_pkg::op_set_const, a, k};
    endfunction

    function automatic core_pkg::insn_t bnz_insn(input core_pkg::reg_ptr_t c,
                                                 input core_pkg::insn_ptr_t target);
        return {core_pkg::op_bnz, 3'b000, target, c};
    endfunction

    task automatic new_program(input core_pkg::insn_t fill);
        for (int i = 0; i < core_pkg::insn_count; i++)
            prog[i] = fill;
        prog_len = 0;
    endtask

    task automatic emit(input core_pkg::insn_t word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // ISA-level model that logs every bus access
    task automatic run_reference(input logic init_flag, input core_pkg::data_t init_val);
        core_pkg::data_t r [16];
        core_pkg::insn_t w;
        core_pkg::opcode_t op;
        core_pkg::reg_ptr_t a;
        core_pkg::reg_ptr_t b;
        core_pkg::reg_ptr_t c;
        access_t acc;
        int pc;
        int steps;
        for (int i = 0; i < 16; i++)
            r[i] = '0;
        if (init_flag)
            r[0] = init_val;
        for (int i = 0; i < 65536; i++)
            ref_mem[i] = dmem[i];
        exp_log.delete();
        pc = 0;
        steps = 0;
        while (pc < core_pkg::insn_count && steps < 2000)
        begin
            w = prog[pc];
            op = core_pkg::opcode_t'(w[15:12]);
            a = w[11:8];
            b = w[7:4];
            c = w[3:0];
            pc++;
            steps++;
            case (op)
                core_pkg::op_add:       r[c] = r[a] + r[b];
                core_pkg::op_sub:       r[c] = r[a] - r[b];
                core_pkg::op_mul:       r[c] = r[a] * r[b];
                core_pkg::op_div:       r[c] = (r[b] == 0) ? 8'hff : r[a] / r[b];
                core_pkg::op_cmpge:     r[c] = (r[a] >= r[b]) ? 8'd1 : 8'd0;
                core_pkg::op_rshift:    r[c] = r[a] >> r[b][2:0];
                core_pkg::op_lshift:    r[c] = r[a] << r[b][2:0];
                core_pkg::op_and:       r[c] = r[a] & r[b];
                core_pkg::op_or:        r[c] = r[a] | r[b];
                core_pkg::op_xor:       r[c] = r[a] ^ r[b];
                core_pkg::op_set_const: r[a] = w[7:0];
                core_pkg::op_bnz:       if (r[c] != 0) pc = w[8:4];
                core_pkg::op_halt:      pc = core_pkg::insn_count;
                core_pkg::op_ld, core_pkg::op_st:
                begin
                    acc.addr = {r[a], r[b]};
                    if (op == core_pkg::op_ld)
                    begin
                        acc.op = core_pkg::mem_load;
                        acc.data = ref_mem[acc.addr];
                        r[c] = acc.data;
                    end
                    else
                    begin
                        acc.op = core_pkg::mem_store;
                        acc.data = r[c];
                        ref_mem[acc.addr] = r[c];
                    end
                    exp_log.push_back(acc);
                end
                default: ;
            endcase
        end
    endtask

    task automatic run_program(input logic init_flag, input core_pkg::data_t init_val);
        int cycles;
        run_reference(init_flag, init_val);
        bus_log.delete();
        @(negedge clk);
        insn_data = prog;
        init_r0_flag = init_flag;
        init_r0_data = init_val;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("ready", ready, 1'b0);
        cycles = 0;
        while (ready !== 1'b1 && cycles < run_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (ready !== 1'b1)
            report_failure($sformatf("core did not raise ready within %0d cycles", run_limit));
        check_value("bus access count", bus_log.size(), exp_log.size());
        foreach (exp_log[i])
        begin
            check_value("enable", bus_log[i].op, exp_log[i].op);
            check_value("addr", bus_log[i].addr, exp_log[i].addr);
            check_value(exp_log[i].op == core_pkg::mem_store ? "wr_data" : "rd_data",
                        bus_log[i].data, exp_log[i].data);
        end
    endtask

    task automatic test_reset();
        check_value("ready", ready, 1'b1);
        check_value("enable", enable, core_pkg::mem_none);
        new_program(halt_word);
        run_program(1'b0, 8'h00);
        check_value("enable", enable, core_pkg::mem_none);
    endtask

    task automatic test_alu();
        for (int round = 0; round < 3; round++)
        begin
            new_program(halt_word);
            emit(const_insn(1, round == 0 ? 8'hb7 : random_byte()));
            emit(const_insn(2, round == 0 ? 8'h2d : random_byte())); // shift of 5 first round
            emit(const_insn(4, 8'h20)); // store page
            for (int v = core_pkg::op_add; v <= core_pkg::op_xor; v++)
            begin
                emit(alu_insn(core_pkg::opcode_t'(v), 1, 2, 5));
                emit(alu_insn(core_pkg::op_st, 4, 5, 5));
            end
            emit(alu_insn(core_pkg::op_div, 1, 3, 5)); // r3 is still zero
            emit(alu_insn(core_pkg::op_st, 4, 5, 5));
            run_program(1'b0, 8'h00);
        end
    endtask

    task automatic test_chain();
        for (int round = 0; round < 3; round++)
        begin
            new_program(halt_word);
            emit(const_insn(1, round == 0 ? 8'h03 : random_byte()));
            emit(alu_insn(core_pkg::op_add, 1, 1, 2));
            emit(alu_insn(core_pkg::op_mul, 2, 2, 3));
            emit(alu_insn(core_pkg::op_sub, 3, 1, 4));
            emit(alu_insn(core_pkg::op_xor, 4, 2, 5));
            emit(alu_insn(core_pkg::op_lshift, 5, 1, 6));
            emit(alu_insn(core_pkg::op_cmpge, 6, 5, 7));
            emit(alu_insn(core_pkg::op_or, 7, 6, 8));
            emit(alu_insn(core_pkg::op_st, 8, 5, 6));
            emit(alu_insn(core_pkg::op_st, 6, 4, 7));
            run_program(1'b0, 8'h00);
        end
    endtask

    task automatic test_memory();
        for (int round = 0; round < 4; round++)
        begin
            new_program(halt_word);
            emit(const_insn(1, 8'h40));
            emit(const_insn(2, 8'h01));
            emit(alu_insn(core_pkg::op_st, 1, 2, 0)); // start value out
            emit(alu_insn(core_pkg::op_ld, 1, 2, 3));
            emit(alu_insn(core_pkg::op_add, 3, 3, 4));
            emit(alu_insn(core_pkg::op_st, 1, 4, 4));
            emit(alu_insn(core_pkg::op_ld, 4, 2, 5)); // untouched location
            emit(alu_insn(core_pkg::op_st, 1, 5, 5));
            emit(alu_insn(core_pkg::op_ld, 1, 5, 6));
            emit(alu_insn(core_pkg::op_st, 2, 6, 6));
            run_program(round != 1, random_byte());
        end
    endtask

    task automatic test_branch();
        new_program(halt_word);
        emit(const_insn(1, 8'd5));
        emit(const_insn(2, 8'd1));
        emit(const_insn(3, 8'h30));
        emit(alu_insn(core_pkg::op_st, 3, 1, 1)); // loop top, slot 3
        emit(alu_insn(core_pkg::op_sub, 1, 2, 1));
        emit(bnz_insn(1, 5'd3));
        emit(alu_insn(core_pkg::op_st, 3, 2, 3)); // in the shadow of the taken branch
        emit(const_insn(4, 8'h99));
        emit(alu_insn(core_pkg::op_st, 3, 4, 4));
        run_program(1'b0, 8'h00);
        new_program(nop_word);
        emit(const_insn(1, 8'h12));
        emit(const_insn(2, 8'h34));
        prog[core_pkg::insn_count-1] = alu_insn(core_pkg::op_st, 1, 2, 2); // no halt anywhere
        run_program(1'b0, 8'h00);
    endtask

    task automatic test_restart();
        new_program(halt_word);
        emit(const_insn(9, 8'h77));
        emit(alu_insn(core_pkg::op_st, 10, 11, 9));
        run_program(1'b1, 8'h5a);
        new_program(halt_word);
        emit(alu_insn(core_pkg::op_st, 10, 11, 9));
        run_program(1'b0, 8'h00);
        check_value("wr_data", bus_log[0].data, 8'h00);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        insn_data = '0;
        init_r0_flag = 1'b0;
        init_r0_data = '0;
        for (int i = 0; i < 65536; i++)
            dmem[i] = core_pkg::data_t'(i >> 8) ^ core_pkg::data_t'(i * 3) ^ 8'ha5;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset();
        test_alu();
        test_chain();
        test_memory();
        test_branch();
        test_restart();
        @(negedge clk);
        if (i_core_top.i_core_assertions.fail_count == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
            report_failure("bus protocol assertions fired during the run");
    end

endmodule

// ==== compile.f ====
core_pkg.sv
insn_memory.sv
register_file.sv
core_decode.sv
core_execute.sv
core_result.sv
core_top.sv
core_assertions.sv
core_tb.sv
